//--- design/mcpu_decode.sv
`timescale 1ns/10ps

module mcpu_decode (
  input  mcpu_pkg::word_t                inst,
  input  mcpu_pkg::word_t                nextinst,
  input  logic [mcpu_pkg::NUM_PREDS-1:0] preds,
  input  logic                           prev_long_imm,
  input  logic [mcpu_pkg::NUM_REGS-1:0]  reg_scoreboard,
  input  logic [mcpu_pkg::NUM_PREDS-1:0] pred_scoreboard,
  input  mcpu_pkg::word_t                rs_data,
  input  mcpu_pkg::word_t                rt_data,
  output mcpu_pkg::reg_num_t             rs_num,
  output mcpu_pkg::reg_num_t             rt_num,
  output mcpu_pkg::issue_bundle_t        bundle,
  output logic                           dep_stall
);
  import mcpu_pkg::*;

  opcode_t    opcode;
  pred_num_t  guard_num;
  logic [3:0] pred_vals;
  logic [3:0] pred_busy;
  logic       active;
  logic       depend_rs;
  logic       depend_rt;

  assign opcode    = {inst[23:19], inst[13:10]};
  assign guard_num = inst[31:30];
  assign rs_num    = inst[4:0];
  assign rt_num    = inst[18:14];
  assign pred_vals = {1'b1, preds};              // Index 3 always true
  assign pred_busy = {1'b0, pred_scoreboard};    // and never busy

  // Guard true and not the operand word of a long immediate
  assign active = (pred_vals[guard_num] ^ inst[29]) & ~prev_long_imm;

  always_comb begin
    bundle            = '0;
    bundle.opcode     = opcode;
    bundle.oper_type  = OPER_TYPE_ALU;
    bundle.rd_num     = inst[9:5];
    bundle.op1        = rs_data;
    bundle.link_bit   = inst[25];
    bundle.lsu_offset = opcode[2] ? {inst[24:19], inst[13], inst[9:5]}  // Store form
                                  : inst[24:13];                        // Load form
    depend_rs = 1'b0;
    depend_rt = 1'b0;

    if (active) begin
      if (!inst[28]) begin                       // ALU short immediate
        bundle.rd_we        = opcode[3:0] != 4'b0111;  // Compares write a predicate
        bundle.pred_we      = ~bundle.rd_we;
        bundle.shift_type   = 2'b11;
        bundle.shift_amount = {1'b0, inst[17:14], 1'b0};
        bundle.op2[9:0]     = inst[27:18];
        if (opcode[3]) begin                     // 1-op form extends the immediate with rs
          bundle.op2[14:10] = inst[4:0];
        end else begin
          depend_rs = 1'b1;
        end
      end else if (inst[27:26] == 2'b01) begin   // ALU register
        bundle.op2          = rt_data;
        bundle.rd_we        = opcode[3:0] != 4'b0111;
        bundle.pred_we      = ~bundle.rd_we;
        bundle.shift_amount = {1'b0, inst[25:21]};
        bundle.shift_type   = inst[20:19];
        depend_rt           = 1'b1;
        depend_rs           = ~opcode[3];
      end else if (inst[27:25] == 3'b001) begin  // Load/store
        bundle.oper_type = OPER_TYPE_LSU;
        bundle.op2       = rt_data;
        bundle.rd_we     = ~opcode[2];           // Loads write rd
        depend_rs        = 1'b1;
        depend_rt        = opcode[2];            // Stores read rt
      end else if (inst[27]) begin               // Branch
        bundle.oper_type = OPER_TYPE_BRANCH;
        bundle.rd_num    = 5'd31;                // Link register
        bundle.rd_we     = inst[25];
        if (inst[26]) begin                      // Register target
          depend_rs          = 1'b1;
          bundle.op2[23:4]   = inst[24:5];
        end else begin                           // Immediate target
          bundle.op2[28:4]   = inst[24:0];
        end
      end else if (inst[24]) begin               // Other
        bundle.oper_type = OPER_TYPE_OTHER;
        bundle.op2       = rt_data;
        case (opcode[8:5])
          4'b0001, 4'b0010, 4'b0011, 4'b0100: begin  // BREAK, SYSCALL, FENCE, ERET
            bundle.invalid = 1'b0;
          end
          4'b0101, 4'b0111, 4'b1011: begin       // FLUSH, MTC, MTHI
            depend_rs = 1'b1;
          end
          4'b0110, 4'b1010: begin                // MFC, MFHI
            bundle.rd_we = 1'b1;
          end
          4'b1000, 4'b1001: begin                // MULT, DIV
            depend_rs    = 1'b1;
            depend_rt    = 1'b1;
            bundle.rd_we = 1'b1;
          end
          default: begin
            bundle.invalid = 1'b1;
          end
        endcase
      end else if (inst[22]) begin
        bundle.invalid = 1'b1;
      end else if (inst[23]) begin               // Register shift
        depend_rs         = 1'b1;
        depend_rt         = 1'b1;
        bundle.rd_we      = 1'b1;
        bundle.shift_type = inst[20:19];
        bundle.op2        = rt_data;
        // Any amount of 32 or more shifts everything out
        bundle.shift_amount = (|rs_data[31:5]) ? 6'd32 : {1'b0, rs_data[4:0]};
      end else if (|inst[20:14]) begin
        bundle.invalid = 1'b1;
      end else begin                             // ALU long immediate
        bundle.op2      = nextinst;
        bundle.long_imm = 1'b1;
        bundle.pred_we  = opcode[3:0] == 4'b0111;
        bundle.rd_we    = ~bundle.pred_we;
        depend_rs       = ~opcode[3];
      end
    end
  end

  // A squashed operand word has no guard to wait on
  assign dep_stall = (depend_rt & reg_scoreboard[rt_num]) |
                     (depend_rs & reg_scoreboard[rs_num]) |
                     (pred_busy[guard_num] & ~prev_long_imm) |
                     (bundle.rd_we & reg_scoreboard[bundle.rd_num]) |
                     (bundle.pred_we & pred_busy[bundle.rd_num[1:0]]);

endmodule

//--- design/mcpu_issue_reg.sv
`timescale 1ns/10ps

module mcpu_issue_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    accept,
  input  mcpu_pkg::issue_bundle_t bundle_in,
  output logic                    prev_long_imm,
  output logic                    issue_valid,
  output mcpu_pkg::issue_bundle_t issue
);
  import mcpu_pkg::*;

  issue_bundle_t issue_q;

  // One issue pulse per accepted word including squashed ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid   <= 1'b0;
      prev_long_imm <= 1'b0;
    end else begin
      issue_valid <= accept;
      if (accept) begin
        prev_long_imm <= bundle_in.long_imm;     // Held while fetch is stalled
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_q <= bundle_in;
    end
  end

  assign issue = issue_q;

endmodule

//--- design/mcpu_issue_top.sv
`timescale 1ns/10ps

module mcpu_issue_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    inst_valid,
  input  mcpu_pkg::word_t         inst,
  input  mcpu_pkg::word_t         nextinst,
  input  mcpu_pkg::reg_wb_t       reg_wb,
  input  mcpu_pkg::pred_wb_t      pred_wb,
  output logic                    stall,
  output logic                    issue_valid,
  output mcpu_pkg::issue_bundle_t issue
);
  import mcpu_pkg::*;

  reg_num_t             rs_num;
  reg_num_t             rt_num;
  word_t                rs_data;
  word_t                rt_data;
  logic [NUM_PREDS-1:0] preds;
  logic [NUM_REGS-1:0]  reg_scoreboard;
  logic [NUM_PREDS-1:0] pred_scoreboard;
  issue_bundle_t        bundle;
  logic                 dep_stall;
  logic                 prev_long_imm;
  logic                 accept;

  assign stall  = inst_valid & dep_stall;        // Fetch holds its word
  assign accept = inst_valid & ~dep_stall;

  mcpu_decode decode_i (
    .inst            (inst),
    .nextinst        (nextinst),
    .preds           (preds),
    .prev_long_imm   (prev_long_imm),
    .reg_scoreboard  (reg_scoreboard),
    .pred_scoreboard (pred_scoreboard),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .bundle          (bundle),
    .dep_stall       (dep_stall)
  );

  mcpu_regfile regfile_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_num  (rs_num),
    .rt_num  (rt_num),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .reg_wb  (reg_wb),
    .pred_wb (pred_wb),
    .preds   (preds)
  );

  mcpu_scoreboard scoreboard_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_en        (accept),
    .bundle          (bundle),
    .reg_wb          (reg_wb),
    .pred_wb         (pred_wb),
    .reg_scoreboard  (reg_scoreboard),
    .pred_scoreboard (pred_scoreboard)
  );

  mcpu_issue_reg issue_reg_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept        (accept),
    .bundle_in     (bundle),
    .prev_long_imm (prev_long_imm),
    .issue_valid   (issue_valid),
    .issue         (issue)
  );

endmodule

//--- design/mcpu_pkg.sv
package mcpu_pkg;

  localparam int NUM_REGS  = 32;
  localparam int NUM_PREDS = 3;    // Index 3 is the hardwired true predicate

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_num_t;
  typedef logic [1:0]  pred_num_t;
  typedef logic [8:0]  opcode_t;   // {inst[23:19], inst[13:10]}
  typedef logic [2:0]  oper_type_t;
  typedef logic [1:0]  shift_type_t;
  typedef logic [5:0]  shift_amt_t;
  typedef logic [11:0] lsu_off_t;

  // Execute unit selection
  localparam oper_type_t OPER_TYPE_ALU    = 3'd0;
  localparam oper_type_t OPER_TYPE_LSU    = 3'd1;
  localparam oper_type_t OPER_TYPE_BRANCH = 3'd2;
  localparam oper_type_t OPER_TYPE_OTHER  = 3'd3;

  // Everything execute needs for one word
  typedef struct packed {
    opcode_t     opcode;
    oper_type_t  oper_type;
    shift_type_t shift_type;
    shift_amt_t  shift_amount;
    reg_num_t    rd_num;        // Low two bits name the predicate on compares
    logic        rd_we;
    logic        pred_we;
    word_t       op1;
    word_t       op2;
    lsu_off_t    lsu_offset;
    logic        long_imm;      // Next word is the operand
    logic        link_bit;
    logic        invalid;
  } issue_bundle_t;

  // Register writeback strobe from execute
  typedef struct packed {
    logic     en;
    reg_num_t num;
    word_t    data;
  } reg_wb_t;

  // Predicate writeback strobe from execute
  typedef struct packed {
    logic      en;
    pred_num_t num;
    logic      val;
  } pred_wb_t;

endpackage

//--- design/mcpu_regfile.sv
`timescale 1ns/10ps

module mcpu_regfile (
  input  logic                           clk,
  input  logic                           rst_n,
  input  mcpu_pkg::reg_num_t             rs_num,
  input  mcpu_pkg::reg_num_t             rt_num,
  output mcpu_pkg::word_t                rs_data,
  output mcpu_pkg::word_t                rt_data,
  input  mcpu_pkg::reg_wb_t              reg_wb,
  input  mcpu_pkg::pred_wb_t             pred_wb,
  output logic [mcpu_pkg::NUM_PREDS-1:0] preds
);
  import mcpu_pkg::*;

  word_t regs [NUM_REGS];

  // Reads see the value before a same-cycle writeback
  assign rs_data = regs[rs_num];
  assign rt_data = regs[rt_num];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wb.en) begin
      regs[reg_wb.num] <= reg_wb.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      preds <= '0;
    end else if (pred_wb.en && pred_wb.num < NUM_PREDS) begin  // Index 3 is read-only
      preds[pred_wb.num] <= pred_wb.val;
    end
  end

endmodule

//--- design/mcpu_scoreboard.sv
`timescale 1ns/10ps

module mcpu_scoreboard (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           issue_en,
  input  mcpu_pkg::issue_bundle_t        bundle,
  input  mcpu_pkg::reg_wb_t              reg_wb,
  input  mcpu_pkg::pred_wb_t             pred_wb,
  output logic [mcpu_pkg::NUM_REGS-1:0]  reg_scoreboard,
  output logic [mcpu_pkg::NUM_PREDS-1:0] pred_scoreboard
);
  import mcpu_pkg::*;

  logic [NUM_REGS-1:0]  reg_set;
  logic [NUM_REGS-1:0]  reg_clr;
  logic [NUM_PREDS-1:0] pred_set;
  logic [NUM_PREDS-1:0] pred_clr;

  always_comb begin
    reg_set  = '0;
    reg_clr  = '0;
    pred_set = '0;
    pred_clr = '0;
    if (issue_en && bundle.rd_we) begin
      reg_set[bundle.rd_num] = 1'b1;             // Destination pending
    end
    if (issue_en && bundle.pred_we && bundle.rd_num[1:0] < NUM_PREDS) begin
      pred_set[bundle.rd_num[1:0]] = 1'b1;
    end
    if (reg_wb.en) begin
      reg_clr[reg_wb.num] = 1'b1;                // Result arrived
    end
    if (pred_wb.en && pred_wb.num < NUM_PREDS) begin
      pred_clr[pred_wb.num] = 1'b1;
    end
  end

  // Issue never targets a busy bit, so set and clear are disjoint
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_scoreboard  <= '0;
      pred_scoreboard <= '0;
    end else begin
      reg_scoreboard  <= (reg_scoreboard & ~reg_clr) | reg_set;
      pred_scoreboard <= (pred_scoreboard & ~pred_clr) | pred_set;
    end
  end

endmodule

//--- files.f
design/mcpu_pkg.sv
design/mcpu_decode.sv
design/mcpu_regfile.sv
design/mcpu_scoreboard.sv
design/mcpu_issue_reg.sv
design/mcpu_issue_top.sv
tb/mcpu_issue_tb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module mcpu_issue_tb -f files.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vmcpu_issue_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tb/mcpu_issue_tb.sv
`timescale 1ns/10ps

module mcpu_issue_tb;
  import mcpu_pkg::*;

  localparam int NUM_INSTR      = 78;                    // Words sent over all tests
  localparam int TIMEOUT_CYCLES = 20 * NUM_INSTR + 100;

  logic          clk;
  logic          rst_n;
  logic          inst_valid;
  word_t         inst;
  word_t         nextinst;
  reg_wb_t       reg_wb;
  pred_wb_t      pred_wb;
  logic          stall;
  logic          issue_valid;
  issue_bundle_t issue;

  // Architectural model
  word_t                m_regs [NUM_REGS];
  logic [NUM_PREDS-1:0] m_preds;
  logic [NUM_PREDS-1:0] m_pred_busy;
  logic [NUM_REGS-1:0]  m_reg_busy;
  logic                 m_prev_long;

  logic          exp_valid;
  issue_bundle_t exp_issue;
  issue_bundle_t last_issue;
  int            check_cnt;
  int            err_cnt;
  int            err_mark;
  int            stall_cnt;
  int            cycle_cnt;
  int            seed;

  mcpu_issue_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .nextinst    (nextinst),
    .reg_wb      (reg_wb),
    .pred_wb     (pred_wb),
    .stall       (stall),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Expected decode of one word against the model state
  function automatic issue_bundle_t decode_ref(input word_t w, input word_t nw,
                                               output logic stl);
    issue_bundle_t b;
    logic [3:0]    pv;
    logic [3:0]    pb;
    logic          need_rs;
    logic          need_rt;
    word_t         rs_v;
    word_t         rt_v;
    rs_v    = m_regs[w[4:0]];
    rt_v    = m_regs[w[18:14]];
    pv      = {1'b1, m_preds};
    pb      = {1'b0, m_pred_busy};
    need_rs = 1'b0;
    need_rt = 1'b0;
    b            = '0;
    b.opcode     = {w[23:19], w[13:10]};
    b.rd_num     = w[9:5];
    b.op1        = rs_v;
    b.link_bit   = w[25];
    b.lsu_offset = w[12] ? {w[24:19], w[13], w[9:5]} : w[24:13];
    if ((pv[w[31:30]] ^ w[29]) && !m_prev_long) begin
      if (w[28] == 1'b0) begin                   // ALU short
        b.rd_we        = w[13:10] != 4'b0111;
        b.pred_we      = w[13:10] == 4'b0111;
        b.shift_type   = 2'b11;
        b.shift_amount = {1'b0, w[17:14], 1'b0};
        b.op2          = w[13] ? {17'b0, w[4:0], w[27:18]} : {22'b0, w[27:18]};
        need_rs        = !w[13];
      end else if (w[27:26] == 2'b01) begin      // ALU register
        b.rd_we        = w[13:10] != 4'b0111;
        b.pred_we      = w[13:10] == 4'b0111;
        b.shift_type   = w[20:19];
        b.shift_amount = {1'b0, w[25:21]};
        b.op2          = rt_v;
        need_rs        = !w[13];
        need_rt        = 1'b1;
      end else if (w[27:25] == 3'b001) begin
        b.oper_type = OPER_TYPE_LSU;
        b.op2       = rt_v;
        b.rd_we     = !w[12];
        need_rs     = 1'b1;
        need_rt     = w[12];
      end else if (w[27]) begin
        b.oper_type = OPER_TYPE_BRANCH;
        b.rd_num    = 5'd31;
        b.rd_we     = w[25];
        b.op2       = w[26] ? {8'b0, w[24:5], 4'b0} : {3'b0, w[24:0], 4'b0};
        need_rs     = w[26];
      end else if (w[24]) begin
        b.oper_type = OPER_TYPE_OTHER;
        b.op2       = rt_v;
        case (w[23:20])
          4'd1, 4'd2, 4'd3, 4'd4: b.invalid = 1'b0;
          4'd5, 4'd7, 4'd11:      need_rs = 1'b1;
          4'd6, 4'd10:            b.rd_we = 1'b1;
          4'd8, 4'd9: begin
            b.rd_we = 1'b1;
            need_rs = 1'b1;
            need_rt = 1'b1;
          end
          default:                b.invalid = 1'b1;
        endcase
      end else if (w[22] || (!w[23] && w[20:14] != 7'd0)) begin
        b.invalid = 1'b1;
      end else if (w[23]) begin                  // Register shift
        b.rd_we        = 1'b1;
        b.shift_type   = w[20:19];
        b.shift_amount = (rs_v > 32'd31) ? 6'd32 : rs_v[5:0];
        b.op2          = rt_v;
        need_rs        = 1'b1;
        need_rt        = 1'b1;
      end else begin                             // Long immediate
        b.long_imm = 1'b1;
        b.op2      = nw;
        b.pred_we  = w[13:10] == 4'b0111;
        b.rd_we    = w[13:10] != 4'b0111;
        need_rs    = !w[13];
      end
    end
    stl = (need_rt && m_reg_busy[w[18:14]]) || (need_rs && m_reg_busy[w[4:0]]) ||
          (pb[w[31:30]] && !m_prev_long) || (b.rd_we && m_reg_busy[b.rd_num]) ||
          (b.pred_we && pb[b.rd_num[1:0]]);
    return b;
  endfunction

  function automatic word_t alu_short(input pred_num_t guard, input logic neg,
                                      input logic [3:0] op, input reg_num_t rd,
                                      input reg_num_t rs);
    return {guard, neg, 1'b0, 10'h155, 4'h3, op, rd, rs};
  endfunction

  task automatic check_bundle(input string name, input issue_bundle_t exp,
                              input issue_bundle_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
    end
  endtask

  // Model and checks step on the falling edge
  always @(negedge clk) begin
    issue_bundle_t b;
    logic          stl;
    if (rst_n) begin
      check_bit("issue_valid", exp_valid, issue_valid);
      if (issue_valid && exp_valid) begin
        check_bundle("issue", exp_issue, issue);
        last_issue = issue;
      end
      exp_valid = 1'b0;
      b = decode_ref(inst, nextinst, stl);
      check_bit("stall", inst_valid & stl, stall);
      if (stall) begin
        stall_cnt++;
      end
      if (inst_valid && !stl) begin              // Taken on the next rising edge
        exp_valid   = 1'b1;
        exp_issue   = b;
        m_prev_long = b.long_imm;
        if (b.rd_we) m_reg_busy[b.rd_num] = 1'b1;
        if (b.pred_we && b.rd_num[1:0] != 2'd3) m_pred_busy[b.rd_num[1:0]] = 1'b1;
      end
      if (reg_wb.en) begin
        m_regs[reg_wb.num]     = reg_wb.data;
        m_reg_busy[reg_wb.num] = 1'b0;
      end
      if (pred_wb.en && pred_wb.num != 2'd3) begin
        m_preds[pred_wb.num]     = pred_wb.val;
        m_pred_busy[pred_wb.num] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a word was never accepted", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic send_word(input word_t w, input word_t nw);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst       <= w;
    nextinst   <= nw;
    @(negedge clk);
    while (stall) begin                          // Fetch holds the word
      @(negedge clk);
    end
    @(posedge clk);                              // Accepted here
    inst_valid <= 1'b0;
    @(posedge clk);
  endtask

  task automatic write_reg(input reg_num_t num, input word_t data);
    reg_wb_t wb;
    wb.en   = 1'b1;
    wb.num  = num;
    wb.data = data;
    @(posedge clk);
    reg_wb <= wb;
    @(posedge clk);
    reg_wb <= '0;
  endtask

  task automatic write_pred(input pred_num_t num, input logic val);
    pred_wb_t wb;
    wb.en  = 1'b1;
    wb.num = num;
    wb.val = val;
    @(posedge clk);
    pred_wb <= wb;
    @(posedge clk);
    pred_wb <= '0;
  endtask

  task automatic retire_all();
    word_t rnd;
    for (int r = 0; r < NUM_REGS; r++) begin
      if (m_reg_busy[r]) write_reg(r[4:0], $urandom);
    end
    for (int p = 0; p < NUM_PREDS; p++) begin
      rnd = $urandom;
      if (m_pred_busy[p]) write_pred(p[1:0], rnd[0]);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    word_t w;
    word_t imm;
    logic  exp_inv;
    seed        = $urandom(32'h4144);
    rst_n       = 1'b0;
    inst_valid  = 1'b0;
    inst        = '0;
    nextinst    = '0;
    reg_wb      = '0;
    pred_wb     = '0;
    m_preds     = '0;
    m_pred_busy = '0;
    m_reg_busy  = '0;
    m_prev_long = 1'b0;
    exp_valid   = 1'b0;
    last_issue  = '0;
    check_cnt   = 0;
    err_cnt     = 0;
    err_mark    = 0;
    stall_cnt   = 0;
    cycle_cnt   = 0;
    for (int r = 0; r < NUM_REGS; r++) m_regs[r] = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (int r = 0; r < NUM_REGS; r++) write_reg(r[4:0], $urandom);  // Preload
    for (int i = 0; i < 40; i++) begin
      w = $urandom;
      w[31:29] = 3'b110;                         // Always-true guard
      if (i[0]) w[28:26] = 3'b101;
      else      w[28] = 1'b0;
      if ($urandom % 4 == 0) w[13:10] = 4'b0111; // Compare
      send_word(w, $urandom);
      retire_all();
    end
    end_test("alu short and register");

    for (int i = 0; i < 6; i++) begin
      w = $urandom;
      w[31:25] = 7'b1101001;
      w[12]    = i[0];                           // Loads and stores alternate
      send_word(w, $urandom);
      retire_all();
    end
    for (int i = 0; i < 6; i++) begin
      w = $urandom;
      w[31:26] = {5'b11011, i[0]};
      send_word(w, $urandom);
      check_word("rd_num", 32'd31, {27'b0, last_issue.rd_num});
      check_bit("link_bit", w[25], last_issue.link_bit);
      retire_all();
    end
    for (int code = 0; code < 16; code++) begin
      w = $urandom;
      w[31:20] = {8'b11010001, code[3:0]};
      exp_inv  = code == 0 || code > 11;
      send_word(w, $urandom);
      check_bit("invalid", exp_inv, last_issue.invalid);
      retire_all();
    end
    end_test("load/store, branch and other");

    write_reg(5'd12, 32'd40);
    w = {3'b110, 4'b1000, 3'b010, 1'b1, 2'b01, 5'd0, 4'd0, 5'd10, 5'd12};
    send_word(w, $urandom);
    check_word("shift_amount", 32'd32, {26'b0, last_issue.shift_amount});
    retire_all();
    write_reg(5'd12, 32'd7);
    send_word(w, $urandom);
    check_word("shift_amount", 32'd7, {26'b0, last_issue.shift_amount});
    retire_all();
    end_test("register shift");

    send_word(alu_short(2'd3, 1'b0, 4'b1000, 5'd5, 5'd0), $urandom);
    imm       = $urandom;
    stall_cnt = 0;
    fork
      send_word(alu_short(2'd3, 1'b0, 4'b0000, 5'd6, 5'd5), $urandom);
      begin
        repeat (4) @(posedge clk);
        write_reg(5'd5, imm);
      end
    join
    check_bit("stall_seen", 1'b1, stall_cnt != 0);
    check_word("op1", imm, last_issue.op1);
    retire_all();
    send_word(alu_short(2'd3, 1'b0, 4'b0111, 5'd1, 5'd0), $urandom);  // Writes p1
    stall_cnt = 0;
    fork
      send_word(alu_short(2'd1, 1'b0, 4'b1001, 5'd7, 5'd0), $urandom);
      begin
        repeat (4) @(posedge clk);
        write_pred(2'd1, 1'b1);
      end
    join
    check_bit("stall_seen", 1'b1, stall_cnt != 0);
    check_bit("rd_we", 1'b1, last_issue.rd_we);
    retire_all();
    end_test("register and predicate hazards");

    w   = {3'b110, 4'b1000, 3'b000, 1'b1, 7'd0, 4'b0010, 5'd4, 5'd0};
    imm = $urandom;
    send_word(w, imm);
    check_word("op2", imm, last_issue.op2);
    check_bit("long_imm", 1'b1, last_issue.long_imm);
    retire_all();
    send_word(imm, $urandom);                    // Squashed operand word
    check_bit("rd_we", 1'b0, last_issue.rd_we);
    check_bit("pred_we", 1'b0, last_issue.pred_we);
    @(negedge clk);
    check_word("reg_scoreboard", 32'd0, dut_i.reg_scoreboard);
    check_word("pred_scoreboard", 32'd0, {29'b0, dut_i.pred_scoreboard});
    end_test("long immediate");

    send_word(alu_short(2'd3, 1'b0, 4'b1000, 5'd9, 5'd0), $urandom);
    stall_cnt = 0;
    send_word(alu_short(2'd3, 1'b1, 4'b1000, 5'd9, 5'd0), $urandom);  // Guard false
    check_bit("stall_seen", 1'b0, stall_cnt != 0);
    check_bit("rd_we", 1'b0, last_issue.rd_we);
    retire_all();
    end_test("false guard");

    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
